// ==== rtl/slave_macros.svh ====
// Sizes and address map limits of the AHB-Lite word store, included by the RTL and the testbench
`ifndef SLAVE_MACROS_SVH
`define SLAVE_MACROS_SVH

// ********************
// Bus widths
// ********************

// Byte address width
`define AHB_ADDR_W 8

// Data bus width, one word
`define AHB_DATA_W 32

// ********************
// Store and address map
// ********************

// Words held by the store
`define STORE_WORDS 64

// Highest byte address a read may use
`define READ_MAX 127

// Lowest byte address a write may use, writes run to the top of the map
`define WRITE_MIN 64

`endif

// ==== rtl/ahb_pkg.sv ====
// AHB-Lite protocol encodings, referenced by scoped name from the slave and the testbench
package ahb_pkg;

  // ********************
  // HTRANS
  // ********************

  // Transfer type
  // BUSY is accepted like IDLE by the slave
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // ********************
  // HSIZE
  // ********************

  // Transfer size, only the first three fit a 32-bit bus
  typedef enum logic [2:0] {
    BYTE   = 3'b000,
    HALF   = 3'b001,
    WORD   = 3'b010,
    DWORD  = 3'b011,
    LINE4  = 3'b100,
    LINE8  = 3'b101,
    LINE16 = 3'b110,
    LINE32 = 3'b111
  } hsize_e;

  // ********************
  // HBURST
  // ********************

  // Burst kind
  // Only the master side cares, it expands beats itself
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

endpackage

// ==== rtl/slave_pkg.sv ====
// Types private to the AHB-Lite word store slave, referenced by scoped name
package slave_pkg;

  `include "slave_macros.svh"

  // ********************
  // Response FSM
  // ********************

  // States of the response FSM
  // OKAY covers idle cycles and zero-wait data phases
  // ERR_FIRST is the stalled first error cycle
  // ERR_LAST is the completing second error cycle
  typedef enum logic [1:0] {
    RESP_OKAY      = 2'b00,
    RESP_ERR_FIRST = 2'b01,
    RESP_ERR_LAST  = 2'b10
  } resp_state_e;

  // ********************
  // Store addressing
  // ********************

  // Index of one word in the store
  // Byte address bits above the lane bits
  typedef logic [$clog2(`STORE_WORDS)-1:0] word_idx_t;

endpackage

// ==== rtl/ahb_addr_phase.sv ====
// Address phase capture for the AHB-Lite slave, checks each transfer and holds it for the data phase
`timescale 1ns/100ps

`include "slave_macros.svh"

module ahb_addr_phase (
  input  logic                       tb_clk,
  input  logic                       rst_i,
  input  logic                       hsel_i,
  input  logic [`AHB_ADDR_W-1:0]     haddr_i,
  input  ahb_pkg::htrans_e           htrans_i,
  input  ahb_pkg::hsize_e            hsize_i,
  input  logic                       hwrite_i,
  input  logic                       hready_i,
  output slave_pkg::word_idx_t       dp_idx_o,
  output logic [3:0]                 dp_lanes_o,
  output logic                       dp_write_en_o,
  output logic                       dp_err_o
);

  // Address phase is taken this edge
  logic       accept;
  // Legality terms
  logic       map_ok;
  logic       align_ok;
  logic       size_ok;
  logic       legal;
  // Byte lanes touched by the transfer
  logic [3:0] lanes;

  // ********************
  // Accept
  // ********************

  // NONSEQ or SEQ while selected and the bus is ready
  // BUSY and IDLE fall through as no transfer
  assign accept = hsel_i && hready_i &&
                  ((htrans_i == ahb_pkg::NONSEQ) || (htrans_i == ahb_pkg::SEQ));

  // ********************
  // Legality check
  // ********************

  always_comb begin
    // Direction decides which window applies
    if (hwrite_i) begin
      map_ok = (haddr_i >= `AHB_ADDR_W'(`WRITE_MIN));
    end else begin
      map_ok = (haddr_i <= `AHB_ADDR_W'(`READ_MAX));
    end

    // Alignment and lane mask per size
    size_ok = 1'b1;
    case (hsize_i)
      ahb_pkg::BYTE: begin
        align_ok = 1'b1;
        lanes    = 4'b0001 << haddr_i[1:0];
      end
      ahb_pkg::HALF: begin
        align_ok = ~haddr_i[0];
        lanes    = 4'b0011 << {haddr_i[1], 1'b0};
      end
      ahb_pkg::WORD: begin
        align_ok = (haddr_i[1:0] == 2'b00);
        lanes    = 4'b1111;
      end
      default: begin
        // Wider than the bus
        size_ok  = 1'b0;
        align_ok = 1'b0;
        lanes    = 4'b0000;
      end
    endcase

    legal = map_ok && align_ok && size_ok;
  end

  // Refused transfer entering its data phase
  // Response FSM picks this up on the same edge
  assign dp_err_o = accept && !legal;

  // ********************
  // Data phase registers
  // ********************

  // Write enable only for a legal write
  // Held while the bus is stalled, cleared on an idle slot
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      dp_write_en_o <= 1'b0;
    end else if (hready_i) begin
      dp_write_en_o <= accept && legal && hwrite_i;
    end
  end

  // Word index and lanes, only meaningful with an accepted transfer
  always_ff @(posedge tb_clk) begin
    if (accept) begin
      dp_idx_o   <= haddr_i[`AHB_ADDR_W-1:2];
      dp_lanes_o <= lanes;
    end
  end

endmodule

// ==== rtl/ahb_resp_ctrl.sv ====
// Response FSM of the AHB-Lite slave, drives HREADY and HRESP with the two-cycle error
`timescale 1ns/100ps

module ahb_resp_ctrl (
  input  logic tb_clk,
  input  logic rst_i,
  input  logic dp_err_i,
  output logic hready_o,
  output logic hresp_o
);

  slave_pkg::resp_state_e state_q;
  slave_pkg::resp_state_e state_d;

  // ********************
  // Next state
  // ********************

  always_comb begin
    state_d = state_q;
    case (state_q)
      slave_pkg::RESP_OKAY: begin
        // Refused transfer starts its stall
        if (dp_err_i) begin
          state_d = slave_pkg::RESP_ERR_FIRST;
        end
      end
      slave_pkg::RESP_ERR_FIRST: begin
        // Bus stalled, nothing new accepted here
        state_d = slave_pkg::RESP_ERR_LAST;
      end
      slave_pkg::RESP_ERR_LAST: begin
        // Ready again, so the next address phase may be taken
        // Another refused one goes straight into a new stall
        if (dp_err_i) begin
          state_d = slave_pkg::RESP_ERR_FIRST;
        end else begin
          state_d = slave_pkg::RESP_OKAY;
        end
      end
      default: begin
        state_d = slave_pkg::RESP_OKAY;
      end
    endcase
  end

  // ********************
  // State register
  // ********************

  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      state_q <= slave_pkg::RESP_OKAY;
    end else begin
      state_q <= state_d;
    end
  end

  // ********************
  // Outputs
  // ********************

  // Low for the first error cycle only
  assign hready_o = (state_q != slave_pkg::RESP_ERR_FIRST);

  // ERROR through both error cycles
  assign hresp_o = (state_q == slave_pkg::RESP_ERR_FIRST) ||
                   (state_q == slave_pkg::RESP_ERR_LAST);

endmodule

// ==== rtl/word_store.sv ====
// Word storage of the AHB-Lite slave, byte-lane writes and a combinational word read
`timescale 1ns/100ps

`include "slave_macros.svh"

module word_store (
  input  logic                      tb_clk,
  input  logic                      rst_i,
  input  slave_pkg::word_idx_t      idx_i,
  input  logic [`AHB_DATA_W/8-1:0]  lanes_i,
  input  logic                      write_en_i,
  input  logic [`AHB_DATA_W-1:0]    wdata_i,
  output logic [`AHB_DATA_W-1:0]    rdata_o
);

  // Byte lanes per word
  localparam int LANES = `AHB_DATA_W / 8;

  // Storage array
  logic [`AHB_DATA_W-1:0] mem_q [`STORE_WORDS];

  // ********************
  // Write
  // ********************

  // Cleared on reset so reads of unwritten words give zero
  // Only enabled lanes of the addressed word change
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      for (int w = 0; w < `STORE_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (write_en_i) begin
      for (int b = 0; b < LANES; b++) begin
        if (lanes_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ********************
  // Read
  // ********************

  // Whole word, whatever the transfer size
  // Write at the end of one data phase is visible in the next
  assign rdata_o = mem_q[idx_i];

endmodule

// ==== rtl/ahb_lite_slave.sv ====
// Top of the AHB-Lite word store slave, connects address capture, response FSM and storage
`timescale 1ns/100ps

`include "slave_macros.svh"

module ahb_lite_slave (
  input  logic                    tb_clk,
  input  logic                    rst_i,
  // AHB-Lite address and control
  input  logic                    hsel_i,
  input  logic [`AHB_ADDR_W-1:0]  haddr_i,
  input  ahb_pkg::htrans_e        htrans_i,
  input  ahb_pkg::hsize_e         hsize_i,
  input  logic                    hwrite_i,
  // AHB-Lite data
  input  logic [`AHB_DATA_W-1:0]  hwdata_i,
  output logic [`AHB_DATA_W-1:0]  hrdata_o,
  // AHB-Lite response
  output logic                    hready_o,
  output logic                    hresp_o
);

  // ********************
  // Data phase signals
  // ********************

  // Word addressed by the current data phase
  slave_pkg::word_idx_t dp_idx;
  // Byte lanes of the current data phase
  logic [3:0]           dp_lanes;
  // Legal write in the current data phase
  logic                 dp_write_en;
  // Refused transfer being accepted
  logic                 dp_err;

  // ********************
  // Address phase
  // ********************

  // Slave is alone on the bus, own HREADY doubles as HREADYIN
  ahb_addr_phase u_addr_phase (
    .tb_clk        (tb_clk),
    .rst_i         (rst_i),
    .hsel_i        (hsel_i),
    .haddr_i       (haddr_i),
    .htrans_i      (htrans_i),
    .hsize_i       (hsize_i),
    .hwrite_i      (hwrite_i),
    .hready_i      (hready_o),
    .dp_idx_o      (dp_idx),
    .dp_lanes_o    (dp_lanes),
    .dp_write_en_o (dp_write_en),
    .dp_err_o      (dp_err)
  );

  // ********************
  // Response
  // ********************

  ahb_resp_ctrl u_resp_ctrl (
    .tb_clk   (tb_clk),
    .rst_i    (rst_i),
    .dp_err_i (dp_err),
    .hready_o (hready_o),
    .hresp_o  (hresp_o)
  );

  // ********************
  // Storage
  // ********************

  // Write data comes straight off the bus in the data phase
  word_store u_word_store (
    .tb_clk     (tb_clk),
    .rst_i      (rst_i),
    .idx_i      (dp_idx),
    .lanes_i    (dp_lanes),
    .write_en_i (dp_write_en),
    .wdata_i    (hwdata_i),
    .rdata_o    (hrdata_o)
  );

endmodule

// ==== bench/ahb_master_tasks.svh ====
// AHB-Lite master tasks for the testbench, expand one burst into beats and drive the bus pins

// ********************
// Beat addressing
// ********************

// Byte address of one beat
// INCR kinds step by the transfer size
// WRAP kinds stay inside a block of beats times size bytes
function automatic logic [`AHB_ADDR_W-1:0] beat_addr(input logic [`AHB_ADDR_W-1:0] start,
                                                      input ahb_pkg::hburst_e burst,
                                                      input ahb_pkg::hsize_e size,
                                                      input int beat,
                                                      input int beats);
  int step;
  int linear;
  int span;
  step   = 1 << int'(size);
  linear = int'(start) + beat * step;
  span   = beats * step;
  case (burst)
    ahb_pkg::WRAP4, ahb_pkg::WRAP8, ahb_pkg::WRAP16: begin
      // Block base from the start, offset wraps in the block
      return `AHB_ADDR_W'((int'(start) & ~(span - 1)) | (linear & (span - 1)));
    end
    default: begin
      return `AHB_ADDR_W'(linear);
    end
  endcase
endfunction

// ********************
// Pin drivers
// ********************

// Address phase of one beat
task automatic drive_addr(input logic [`AHB_ADDR_W-1:0] addr,
                          input ahb_pkg::htrans_e trans,
                          input ahb_pkg::hsize_e size,
                          input logic write);
  hsel_i   <= 1'b1;
  haddr_i  <= addr;
  htrans_i <= trans;
  hsize_i  <= size;
  hwrite_i <= write;
endtask

// Bus released, no transfer
task automatic drive_idle();
  hsel_i   <= 1'b0;
  htrans_i <= ahb_pkg::IDLE;
endtask

// ********************
// Burst
// ********************

// Runs one table row as back-to-back beats, checks every data phase
task automatic run_burst(input string name,
                         input logic write,
                         input ahb_pkg::hsize_e size,
                         input logic [`AHB_ADDR_W-1:0] start,
                         input ahb_pkg::hburst_e burst,
                         input int beats,
                         input logic [`AHB_DATA_W-1:0] base,
                         input logic exp_err);
  logic [`AHB_ADDR_W-1:0] addr [$];
  logic [`AHB_DATA_W-1:0] data [$];
  int                     stalls;
  // Beat addresses and data up front
  for (int b = 0; b < beats; b++) begin
    addr.push_back(beat_addr(start, burst, size, b, beats));
    if (write && (size < ahb_pkg::WORD)) begin
      // Narrow writes carry random lane data
      data.push_back($urandom);
    end else begin
      data.push_back(base + 32'(b));
    end
  end
  @(posedge tb_clk);
  drive_addr(addr[0], ahb_pkg::NONSEQ, size, write);
  for (int b = 0; b < beats; b++) begin
    // Slave ready here, this edge takes beat b
    @(posedge tb_clk);
    if (b + 1 < beats) begin
      drive_addr(addr[b + 1], ahb_pkg::SEQ, size, write);
    end else begin
      drive_idle();
    end
    if (write) begin
      hwdata_i <= data[b];
    end
    stalls = 0;
    @(negedge tb_clk);
    // Wait states, only the first error cycle
    while (!hready_o) begin
      check_value(name, 32'd1, {31'b0, hresp_o});
      stalls++;
      @(negedge tb_clk);
    end
    // Completing cycle of the data phase
    check_value(name, {31'b0, exp_err}, {31'b0, hresp_o});
    check_value(name, exp_err ? 32'd1 : 32'd0, 32'(stalls));
    if (!write && !exp_err) begin
      check_value(name, ref_word(addr[b]), hrdata_o);
    end
    if (write && !exp_err) begin
      ref_write(addr[b], size, data[b]);
    end
  end
  // Edge that ends the last data phase
  @(posedge tb_clk);
endtask

// ==== bench/tb_ahb_lite_slave.sv ====
// Testbench for the AHB-Lite word store slave, runs a table of bursts against a byte reference model
`timescale 1ns/100ps

`include "slave_macros.svh"

module tb_ahb_lite_slave;

  localparam int RESET_CYCLES = 10;

  // DUT pins
  logic                   tb_clk;
  logic                   rst_i;
  logic                   hsel_i;
  logic [`AHB_ADDR_W-1:0] haddr_i;
  ahb_pkg::htrans_e       htrans_i;
  ahb_pkg::hsize_e        hsize_i;
  logic                   hwrite_i;
  logic [`AHB_DATA_W-1:0] hwdata_i;
  logic [`AHB_DATA_W-1:0] hrdata_o;
  logic                   hready_o;
  logic                   hresp_o;

  // Table columns, one entry per row
  string                  case_name  [$];
  logic                   case_write [$];
  ahb_pkg::hsize_e        case_size  [$];
  logic [`AHB_ADDR_W-1:0] case_addr  [$];
  ahb_pkg::hburst_e       case_burst [$];
  int                     case_beats [$];
  logic [`AHB_DATA_W-1:0] case_base  [$];
  logic                   case_err   [$];

  // Reference memory, one entry per byte address
  logic [7:0] ref_bytes [2**`AHB_ADDR_W];

  // Run limit
  int cycle_count = 0;
  int cycle_limit = 0;
  int total_beats = 0;

  ahb_lite_slave dut (
    .tb_clk   (tb_clk),
    .rst_i    (rst_i),
    .hsel_i   (hsel_i),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hsize_i  (hsize_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o)
  );

  // ********************
  // Checking
  // ********************

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1, "Stopped at the first wrong value");
    end
  endtask

  // Whole word around a byte address, little endian lanes
  function automatic logic [31:0] ref_word(input logic [`AHB_ADDR_W-1:0] addr);
    logic [`AHB_ADDR_W-1:0] w;
    w = {addr[`AHB_ADDR_W-1:2], 2'b00};
    return {ref_bytes[w + 8'd3], ref_bytes[w + 8'd2], ref_bytes[w + 8'd1], ref_bytes[w]};
  endfunction

  // Byte at address a rides on lane a mod 4
  task automatic ref_write(input logic [`AHB_ADDR_W-1:0] addr, input ahb_pkg::hsize_e size,
                           input logic [31:0] data);
    logic [`AHB_ADDR_W-1:0] a;
    for (int o = 0; o < (1 << int'(size)); o++) begin
      a = addr + `AHB_ADDR_W'(o);
      ref_bytes[a] = data[int'(a[1:0]) * 8 +: 8];
    end
  endtask

  `include "ahb_master_tasks.svh"

  // ********************
  // Test table
  // ********************

  task automatic add_case(input string name, input logic write, input ahb_pkg::hsize_e size,
                          input logic [7:0] addr, input ahb_pkg::hburst_e burst,
                          input int beats, input logic [31:0] base, input logic err);
    case_name.push_back(name);
    case_write.push_back(write);
    case_size.push_back(size);
    case_addr.push_back(addr);
    case_burst.push_back(burst);
    case_beats.push_back(beats);
    case_base.push_back(base);
    case_err.push_back(err);
  endtask

  task automatic build_table();
    // Reset contents and single transfers
    add_case("reset_rd100", 1'b0, ahb_pkg::WORD, 8'd100, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("single_wr64", 1'b1, ahb_pkg::WORD, 8'd64, ahb_pkg::SINGLE, 1, 32'hA5A5_0064, 1'b0);
    add_case("single_rd64", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("half_wr70", 1'b1, ahb_pkg::HALF, 8'd70, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("word_rd68", 1'b0, ahb_pkg::WORD, 8'd68, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    // Incrementing bursts
    add_case("incr4_wr", 1'b1, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR4, 4, 32'h1000_0000, 1'b0);
    add_case("incr4_rd", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR4, 4, 32'h0, 1'b0);
    add_case("incr8_wr", 1'b1, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR8, 8, 32'h2000_0000, 1'b0);
    add_case("incr8_rd", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR8, 8, 32'h0, 1'b0);
    add_case("incr16_wr", 1'b1, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR16, 16, 32'h3000_0000, 1'b0);
    add_case("incr16_rd", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR16, 16, 32'h0, 1'b0);
    add_case("incr7_wr", 1'b1, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR, 7, 32'h4000_0000, 1'b0);
    add_case("incr7_rd", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::INCR, 7, 32'h0, 1'b0);
    // Wrapping bursts off a block boundary
    add_case("wrap4_wr", 1'b1, ahb_pkg::WORD, 8'd68, ahb_pkg::WRAP4, 4, 32'h5000_0000, 1'b0);
    add_case("wrap4_rd", 1'b0, ahb_pkg::WORD, 8'd68, ahb_pkg::WRAP4, 4, 32'h0, 1'b0);
    add_case("wrap8_wr", 1'b1, ahb_pkg::WORD, 8'd68, ahb_pkg::WRAP8, 8, 32'h6000_0000, 1'b0);
    add_case("wrap8_rd", 1'b0, ahb_pkg::WORD, 8'd68, ahb_pkg::WRAP8, 8, 32'h0, 1'b0);
    add_case("wrap16_wr", 1'b1, ahb_pkg::WORD, 8'd68, ahb_pkg::WRAP16, 16, 32'h7000_0000, 1'b0);
    add_case("wrap16_rd", 1'b0, ahb_pkg::WORD, 8'd68, ahb_pkg::WRAP16, 16, 32'h0, 1'b0);
    // Outside the map for the direction
    add_case("map_wr32", 1'b1, ahb_pkg::WORD, 8'd32, ahb_pkg::SINGLE, 1, 32'hDEAD_0000, 1'b1);
    add_case("map_rd128", 1'b0, ahb_pkg::WORD, 8'd128, ahb_pkg::SINGLE, 1, 32'h0, 1'b1);
    add_case("map_wr32_i4", 1'b1, ahb_pkg::WORD, 8'd32, ahb_pkg::INCR4, 4, 32'hDEAD_1000, 1'b1);
    add_case("map_rd128_i4", 1'b0, ahb_pkg::WORD, 8'd128, ahb_pkg::INCR4, 4, 32'h0, 1'b1);
    add_case("rd32_after", 1'b0, ahb_pkg::WORD, 8'd32, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    // Narrow writes and refused sizes
    add_case("byte_wr65", 1'b1, ahb_pkg::BYTE, 8'd65, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("byte_wr67", 1'b1, ahb_pkg::BYTE, 8'd67, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("half_wr66", 1'b1, ahb_pkg::HALF, 8'd66, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("narrow_rd64", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
    add_case("half_mis65", 1'b1, ahb_pkg::HALF, 8'd65, ahb_pkg::SINGLE, 1, 32'h0, 1'b1);
    add_case("dword_wr64", 1'b1, ahb_pkg::DWORD, 8'd64, ahb_pkg::SINGLE, 1, 32'h0, 1'b1);
    add_case("final_rd64", 1'b0, ahb_pkg::WORD, 8'd64, ahb_pkg::SINGLE, 1, 32'h0, 1'b0);
  endtask

  // ********************
  // Clock and timeout
  // ********************

  initial begin
    tb_clk = 1'b0;
    forever #50 tb_clk = ~tb_clk;
  end

  initial begin
    while (cycle_count <= cycle_limit) begin
      @(posedge tb_clk);
      cycle_count++;
    end
    $display("Test failures found");
    $fatal(1, "Timeout, the tests did not finish within %0d cycles", cycle_limit);
  end

  // ********************
  // Main sequence
  // ********************

  initial begin
    void'($urandom(32'h9ae1db23));
    rst_i    <= 1'b1;
    hsel_i   <= 1'b0;
    haddr_i  <= '0;
    htrans_i <= ahb_pkg::IDLE;
    hsize_i  <= ahb_pkg::WORD;
    hwrite_i <= 1'b0;
    hwdata_i <= '0;
    foreach (ref_bytes[a]) begin
      ref_bytes[a] = 8'h00;
    end
    build_table();
    foreach (case_beats[i]) begin
      total_beats += case_beats[i];
    end
    // Four cycles a beat covers error stalls and row gaps
    cycle_limit = 4 * total_beats + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge tb_clk);
    rst_i <= 1'b0;
    @(negedge tb_clk);
    check_value("reset_state", 32'd1, {31'b0, hready_o});
    check_value("reset_state", 32'd0, {31'b0, hresp_o});
    foreach (case_name[i]) begin
      run_burst(case_name[i], case_write[i], case_size[i], case_addr[i], case_burst[i],
                case_beats[i], case_base[i], case_err[i]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+rtl
+incdir+bench
rtl/ahb_pkg.sv
rtl/slave_pkg.sv
rtl/ahb_addr_phase.sv
rtl/ahb_resp_ctrl.sv
rtl/word_store.sv
rtl/ahb_lite_slave.sv
bench/tb_ahb_lite_slave.sv

// ==== Makefile ====
# Verilator build and run of the AHB-Lite slave testbench

TOP := tb_ahb_lite_slave
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): project.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv bench/*.svh)
	verilator --binary --timing --timescale 1ns/100ps \
		--top-module $(TOP) -f project.f -o V$(TOP)

# Exit status of the binary is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
